// File: rtl/ooo_commit_settings.svh
// Widths and buffer depth for the commit back end; CB_DEPTH must be a power of two (4, 8 or 16)
`ifndef OOO_COMMIT_SETTINGS_SVH
`define OOO_COMMIT_SETTINGS_SVH

// Data and address width, one RV32 word
`define XLEN 32

// Architectural register address width
`define REG_W 5

// Number of in-flight entries in the completion buffer
`define CB_DEPTH 8

// Entry index width
`define CB_IDX_W $clog2(`CB_DEPTH)

`endif

// File: rtl/ooo_commit_pkg.sv
// Enums and structs shared by the commit RTL and its testbench; widths follow the settings header
`include "ooo_commit_settings.svh"

package ooo_commit_pkg;

  typedef enum logic [2:0] {ALU, BRANCH, JUMP, LOAD, STORE, SYSTEM} instr_kind_t;  // Opcode class

  typedef enum logic [2:0] {
    NONE, MAL_INSN, MAL_LOAD, MAL_STORE, ILLEGAL, ECALL, BREAK
  } cause_t;

  typedef enum logic [1:0] {FREE, WAIT, DONE} entry_state_t;  // Buffer entry life cycle

  // Dispatch request, one per cycle in program order
  typedef struct packed {
    logic               valid;
    logic [`XLEN-1:0]   pc;
    logic [`REG_W-1:0]  rd;
    instr_kind_t        kind;
  } alloc_req_t;

  typedef struct packed {
    logic                 valid;
    logic [`CB_IDX_W-1:0] index;      // Entry given at allocation
    logic [`REG_W-1:0]    rd;
    logic [`XLEN-1:0]     wdata;
    logic [`XLEN-1:0]     pc;
    logic                 exception;
    cause_t               cause;
  } fu_result_t;

  // Arith result with branch and jump resolution
  typedef struct packed {
    fu_result_t         fu;
    logic               branch_instr;
    logic               jump_instr;
    logic               prediction;    // Taken as predicted at fetch
    logic               branch_taken;
    logic [`XLEN-1:0]   resolved_addr; // Next pc of a branch
    logic [`XLEN-1:0]   jump_addr;
  } arith_result_t;

  typedef struct packed {
    logic                 valid;
    logic [`CB_IDX_W-1:0] index;
    logic                 wen;
    logic [`XLEN-1:0]     wdata;
    logic                 exception;
    cause_t               cause;
    logic                 redirect;
    logic [`XLEN-1:0]     target;
  } cb_write_t;

  typedef struct packed {
    logic               valid;
    logic [`XLEN-1:0]   pc;
    logic               prediction;
    logic               taken;
    logic [`XLEN-1:0]   target;
  } pred_update_t;

  typedef struct packed {
    logic               valid;
    logic [`REG_W-1:0]  rd;
    logic               wen;
    logic [`XLEN-1:0]   wdata;       // Holds the pc on an exception
    logic               exception;
    cause_t             cause;
    logic [`XLEN-1:0]   epc;
    logic               redirect;
    logic [`XLEN-1:0]   target;
  } retire_info_t;

endpackage

// File: rtl/ex_commit_latch.sv
// Execute to commit register; a stall holds all four results, flush and halt clear them all
module ex_commit_latch import ooo_commit_pkg::*; (
  input  logic          CLK,
  input  logic          nRST,
  input  logic          stall,
  input  logic          flush,
  input  logic          halt,
  input  arith_result_t arith_in,
  input  fu_result_t    mul_in,
  input  fu_result_t    div_in,
  input  fu_result_t    ls_in,
  output arith_result_t arith_q,
  output fu_result_t    mul_q,
  output fu_result_t    div_q,
  output fu_result_t    ls_q
);

  logic clear;

  assign clear = flush | halt;  // Younger work dies with a flush

  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      arith_q <= '0;
      mul_q   <= '0;
      div_q   <= '0;
      ls_q    <= '0;
    end else if (clear) begin
      arith_q <= '0;
      mul_q   <= '0;
      div_q   <= '0;
      ls_q    <= '0;
    end else if (~stall) begin
      arith_q <= arith_in;
      mul_q   <= mul_in;
      div_q   <= div_in;
      ls_q    <= ls_in;
    end
  end

endmodule

// File: rtl/commit_writeback.sv
// Commit formatting of latched unit results; no writes leave while stall is high
`include "ooo_commit_settings.svh"

module commit_writeback import ooo_commit_pkg::*; (
  input  arith_result_t arith_q,
  input  fu_result_t    mul_q,
  input  fu_result_t    div_q,
  input  fu_result_t    ls_q,
  input  logic          stall,
  output cb_write_t     arith_wr,
  output cb_write_t     mul_wr,
  output cb_write_t     div_wr,
  output cb_write_t     ls_wr,
  output pred_update_t  pred_update
);

  logic mispredict;
  logic mal_branch;
  logic mal_jump;

  // Common formatting for any unit result
  function automatic cb_write_t fu_write(input fu_result_t res, input logic en);
    cb_write_t w;
    w.valid     = res.valid & en;
    w.index     = res.index;
    w.exception = res.exception;
    w.cause     = res.exception ? res.cause : NONE;
    w.wen       = ~res.exception & (res.rd != '0);  // x0 is never written
    w.wdata     = res.exception ? res.pc : res.wdata;
    w.redirect  = 1'b0;
    w.target    = '0;
    return w;
  endfunction

  assign mispredict = arith_q.branch_instr & (arith_q.prediction ^ arith_q.branch_taken);
  assign mal_branch = arith_q.branch_instr & (arith_q.resolved_addr[1:0] != 2'b00);
  assign mal_jump   = arith_q.jump_instr & (arith_q.jump_addr[1:0] != 2'b00);

  always_comb begin
    arith_wr = fu_write(arith_q.fu, ~stall);
    if (arith_q.fu.exception) begin
      // Unit exception takes priority over target checks
    end else if (mal_branch || mal_jump) begin
      arith_wr.exception = 1'b1;
      arith_wr.cause     = MAL_INSN;
      arith_wr.wdata     = arith_q.fu.pc;
      arith_wr.wen       = 1'b0;
    end else if (arith_q.jump_instr) begin
      arith_wr.wdata    = arith_q.fu.pc + `XLEN'(4);  // Link address
      arith_wr.redirect = 1'b1;
      arith_wr.target   = arith_q.jump_addr;
    end else if (arith_q.branch_instr) begin
      arith_wr.wen      = 1'b0;
      arith_wr.redirect = mispredict;
      arith_wr.target   = arith_q.resolved_addr;
    end
  end

  assign mul_wr = fu_write(mul_q, ~stall);
  assign div_wr = fu_write(div_q, ~stall);
  assign ls_wr  = fu_write(ls_q, ~stall);  // Store wen is masked by kind in the buffer

  // Predictor sees every resolved branch
  always_comb begin
    pred_update.valid      = arith_q.fu.valid & arith_q.branch_instr & ~stall;
    pred_update.pc         = arith_q.fu.pc;
    pred_update.prediction = arith_q.prediction;
    pred_update.taken      = arith_q.branch_taken;
    pred_update.target     = arith_q.resolved_addr;
  end

endmodule

// File: rtl/completion_buffer.sv
// In-order completion buffer; units must write only allocated indices and dispatch must obey cb_full
`include "ooo_commit_settings.svh"

module completion_buffer import ooo_commit_pkg::*; (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 flush,
  input  logic                 halt,
  input  logic                 retire_pop,
  input  alloc_req_t           alloc,
  input  cb_write_t            arith_wr,
  input  cb_write_t            mul_wr,
  input  cb_write_t            div_wr,
  input  cb_write_t            ls_wr,
  output logic [`CB_IDX_W-1:0] alloc_index,
  output logic                 cb_full,
  output retire_info_t         head_entry,
  output logic                 head_done
);

  localparam int NUM_WR = 4;
  localparam logic [`CB_IDX_W:0] FULL_COUNT = `CB_DEPTH;

  // Per-entry payload, no reset needed
  typedef struct packed {
    logic [`XLEN-1:0]  pc;
    logic [`REG_W-1:0] rd;
    instr_kind_t       kind;
    logic              wen;
    logic [`XLEN-1:0]  wdata;
    logic              exception;
    cause_t            cause;
    logic              redirect;
    logic [`XLEN-1:0]  target;
  } slot_t;

  entry_state_t         state [`CB_DEPTH];
  slot_t                slots [`CB_DEPTH];
  cb_write_t            wr [NUM_WR];
  logic [`CB_IDX_W-1:0] head;
  logic [`CB_IDX_W-1:0] tail;
  logic [`CB_IDX_W:0]   count;  // Occupancy
  logic                 clear;
  logic                 alloc_fire;
  slot_t                head_slot;

  assign wr[0] = arith_wr;
  assign wr[1] = mul_wr;
  assign wr[2] = div_wr;
  assign wr[3] = ls_wr;

  assign clear       = flush | halt;
  assign cb_full     = (count == FULL_COUNT);
  assign alloc_fire  = alloc.valid & ~cb_full & ~clear;  // Dropped when flushing
  assign alloc_index = tail;

  // Pointers and occupancy
  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else if (clear) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (alloc_fire) begin
        tail <= tail + 1'b1;  // Wraps at CB_DEPTH
      end
      if (retire_pop) begin
        head <= head + 1'b1;
      end
      case ({alloc_fire, retire_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Entry states
  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      for (int i = 0; i < `CB_DEPTH; i++) begin
        state[i] <= FREE;
      end
    end else if (clear) begin
      for (int i = 0; i < `CB_DEPTH; i++) begin
        state[i] <= FREE;
      end
    end else begin
      if (alloc_fire) begin
        state[tail] <= WAIT;
      end
      for (int p = 0; p < NUM_WR; p++) begin
        if (wr[p].valid && state[wr[p].index] == WAIT) begin
          state[wr[p].index] <= DONE;
        end
      end
      if (retire_pop) begin
        state[head] <= FREE;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (alloc_fire) begin
      slots[tail].pc   <= alloc.pc;
      slots[tail].rd   <= alloc.rd;
      slots[tail].kind <= alloc.kind;
    end
    for (int p = 0; p < NUM_WR; p++) begin
      if (wr[p].valid) begin
        slots[wr[p].index].wen       <= wr[p].wen;
        slots[wr[p].index].wdata     <= wr[p].wdata;
        slots[wr[p].index].exception <= wr[p].exception;
        slots[wr[p].index].cause     <= wr[p].cause;
        slots[wr[p].index].redirect  <= wr[p].redirect;
        slots[wr[p].index].target    <= wr[p].target;
      end
    end
  end

  // Head view for retirement
  always_comb begin
    head_slot            = slots[head];
    head_done            = (state[head] == DONE);
    head_entry.valid     = head_done;
    head_entry.rd        = head_slot.rd;
    head_entry.wen       = head_slot.wen & (head_slot.kind != BRANCH) & (head_slot.kind != STORE);
    head_entry.wdata     = head_slot.wdata;
    head_entry.exception = head_slot.exception;
    head_entry.cause     = head_slot.cause;
    head_entry.epc       = head_slot.pc;
    head_entry.redirect  = head_slot.redirect;
    head_entry.target    = head_slot.target;
  end

endmodule

// File: rtl/retire_unit.sv
// Retires one done head entry per cycle; flush is combinational and lasts only the pop cycle
module retire_unit import ooo_commit_pkg::*; (
  input  logic         CLK,
  input  logic         nRST,
  input  retire_info_t head_entry,
  input  logic         head_done,
  output retire_info_t retire,
  output logic         retire_pop,
  output logic         flush
);

  logic         retire_valid_q;
  retire_info_t retire_data_q;
  logic         trap;

  assign trap       = head_entry.exception | head_entry.redirect;
  assign retire_pop = head_done;          // Head leaves as soon as it is done
  assign flush      = head_done & trap;   // Kills all younger entries

  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      retire_valid_q <= 1'b0;
    end else begin
      retire_valid_q <= head_done;
    end
  end

  // Retire record
  always_ff @(posedge CLK) begin
    if (head_done) begin
      retire_data_q <= head_entry;
    end
  end

  always_comb begin
    retire       = retire_data_q;
    retire.valid = retire_valid_q;
  end

endmodule

// File: rtl/ooo_commit_top.sv
// Commit back end top; dispatch must hold alloc.valid low while cb_full is high
`include "ooo_commit_settings.svh"

module ooo_commit_top import ooo_commit_pkg::*; (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 stall,
  input  logic                 halt,
  input  alloc_req_t           alloc,
  input  arith_result_t        arith_res,
  input  fu_result_t           mul_res,
  input  fu_result_t           div_res,
  input  fu_result_t           ls_res,
  output logic [`CB_IDX_W-1:0] alloc_index,
  output logic                 cb_full,
  output retire_info_t         retire,
  output pred_update_t         pred_update
);

  arith_result_t arith_q;
  fu_result_t    mul_q;
  fu_result_t    div_q;
  fu_result_t    ls_q;
  cb_write_t     arith_wr;
  cb_write_t     mul_wr;
  cb_write_t     div_wr;
  cb_write_t     ls_wr;
  retire_info_t  head_entry;
  logic          head_done;
  logic          retire_pop;
  logic          flush;

  ex_commit_latch latch_i (
    .CLK(CLK), .nRST(nRST), .stall(stall), .flush(flush), .halt(halt),
    .arith_in(arith_res), .mul_in(mul_res), .div_in(div_res), .ls_in(ls_res),
    .arith_q(arith_q), .mul_q(mul_q), .div_q(div_q), .ls_q(ls_q)
  );

  commit_writeback writeback_i (
    .arith_q(arith_q), .mul_q(mul_q), .div_q(div_q), .ls_q(ls_q), .stall(stall),
    .arith_wr(arith_wr), .mul_wr(mul_wr), .div_wr(div_wr), .ls_wr(ls_wr),
    .pred_update(pred_update)
  );

  completion_buffer cb_i (
    .CLK(CLK), .nRST(nRST), .flush(flush), .halt(halt), .retire_pop(retire_pop),
    .alloc(alloc), .arith_wr(arith_wr), .mul_wr(mul_wr), .div_wr(div_wr), .ls_wr(ls_wr),
    .alloc_index(alloc_index), .cb_full(cb_full),
    .head_entry(head_entry), .head_done(head_done)
  );

  retire_unit retire_i (
    .CLK(CLK), .nRST(nRST), .head_entry(head_entry), .head_done(head_done),
    .retire(retire), .retire_pop(retire_pop), .flush(flush)
  );

endmodule

// File: tests/commit_checker.sv
// Compares retire and predictor records in order; any record that was not expected is an error
module commit_checker import ooo_commit_pkg::*; (
  input logic         CLK,
  input logic         nRST,
  input retire_info_t retire,
  input pred_update_t pred_update
);
  timeunit 1ns;
  timeprecision 100ps;

  retire_info_t ret_q [$];
  pred_update_t pred_q [$];
  int           error_count = 0;
  int           test_errors = 0;
  int           tests_run = 0;
  int           tests_failed = 0;
  string        test_name = "none";

  function automatic int pending();
    return ret_q.size() + pred_q.size();
  endfunction

  task automatic expect_retire(input retire_info_t e);
    ret_q.push_back(e);
  endtask

  task automatic expect_pred(input pred_update_t p);
    pred_q.push_back(p);
  endtask

  task automatic note_error(input string msg);
    $display("error at %0t: %s", $time, msg);
    error_count++;
    test_errors++;
  endtask

  task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("mismatch time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
      $display("test %s failed with %0d errors", test_name, test_errors);
    end else begin
      $display("test %s passed", test_name);
    end
  endtask

  task automatic report_counts();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
  endtask

  task automatic compare_retire(input retire_info_t e);
    check_field("retire.epc", e.epc, retire.epc);
    check_field("retire.wen", 32'(e.wen), 32'(retire.wen));
    check_field("retire.exception", 32'(e.exception), 32'(retire.exception));
    check_field("retire.cause", 32'(e.cause), 32'(retire.cause));
    check_field("retire.redirect", 32'(e.redirect), 32'(retire.redirect));
    if (e.wen) check_field("retire.rd", 32'(e.rd), 32'(retire.rd));
    if (e.wen || e.exception) check_field("retire.wdata", e.wdata, retire.wdata);
    if (e.redirect) check_field("retire.target", e.target, retire.target);
  endtask

  task automatic compare_pred(input pred_update_t p);
    check_field("pred_update.pc", p.pc, pred_update.pc);
    check_field("pred_update.prediction", 32'(p.prediction), 32'(pred_update.prediction));
    check_field("pred_update.taken", 32'(p.taken), 32'(pred_update.taken));
    check_field("pred_update.target", p.target, pred_update.target);
  endtask

  // Mid-cycle sampling, outputs are settled here
  always @(negedge CLK) begin
    if (nRST) begin
      if (retire.valid) begin
        if (ret_q.size() == 0) note_error($sformatf("unexpected retire, epc %h", retire.epc));
        else compare_retire(ret_q.pop_front());
      end
      if (pred_update.valid) begin
        if (pred_q.size() == 0) note_error($sformatf("unexpected predictor update, pc %h",
                                                     pred_update.pc));
        else compare_pred(pred_q.pop_front());
      end
    end
  end

endmodule

// File: tests/tb_ooo_commit.sv
// Drives the commit back end from tests/commit_input.txt; run from the project root
`include "ooo_commit_settings.svh"

module tb_ooo_commit import ooo_commit_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_SEQ    = 64;
  localparam int WAIT_LIMIT = 200;  // Cycles

  logic                 CLK;
  logic                 nRST;
  logic                 stall;
  logic                 halt;
  alloc_req_t           alloc;
  arith_result_t        arith_res;
  fu_result_t           mul_res;
  fu_result_t           div_res;
  fu_result_t           ls_res;
  logic [`CB_IDX_W-1:0] alloc_index;
  logic                 cb_full;
  retire_info_t         retire;
  pred_update_t         pred_update;

  logic [`CB_IDX_W-1:0] idx_of [MAX_SEQ];  // Per program-order sequence number
  logic [`XLEN-1:0]     pc_of  [MAX_SEQ];
  logic [`REG_W-1:0]    rd_of  [MAX_SEQ];
  logic [`XLEN-1:0]     rnd_of [MAX_SEQ];
  integer               seed = 96085;

  ooo_commit_top dut_i (
    .CLK(CLK), .nRST(nRST), .stall(stall), .halt(halt), .alloc(alloc),
    .arith_res(arith_res), .mul_res(mul_res), .div_res(div_res), .ls_res(ls_res),
    .alloc_index(alloc_index), .cb_full(cb_full), .retire(retire), .pred_update(pred_update)
  );

  commit_checker chk_i (
    .CLK(CLK), .nRST(nRST), .retire(retire), .pred_update(pred_update)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  task automatic give_up(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $finish;
  endtask

  // Units hold their outputs while stalled
  task automatic cycle();
    @(posedge CLK);
    #2;
    alloc = '0;
    if (!stall) begin
      arith_res = '0;
      mul_res   = '0;
      div_res   = '0;
      ls_res    = '0;
    end
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (chk_i.pending() != 0) begin
      if (n == WAIT_LIMIT) give_up("timed out waiting for an expected retire or update");
      cycle();
      n++;
    end
  endtask

  task automatic do_alloc(input int s, input logic [31:0] pc, input logic [31:0] rd,
                          input logic [31:0] kind);
    int n;
    n = 0;
    while (cb_full) begin
      if (n == WAIT_LIMIT) give_up("timed out waiting for cb_full to drop");
      cycle();
      n++;
    end
    alloc.valid = 1'b1;
    alloc.pc    = pc;
    alloc.rd    = rd[`REG_W-1:0];
    alloc.kind  = instr_kind_t'(kind[2:0]);
    idx_of[s]   = alloc_index;
    pc_of[s]    = pc;
    rd_of[s]    = rd[`REG_W-1:0];
    cycle();
  endtask

  function automatic fu_result_t make_result(input int s, input logic [31:0] wdata,
                                             input logic exc, input logic [31:0] cause);
    fu_result_t r;
    r.valid     = 1'b1;
    r.index     = idx_of[s];
    r.rd        = rd_of[s];
    r.wdata     = wdata;
    r.pc        = pc_of[s];
    r.exception = exc;
    r.cause     = cause_t'(cause[2:0]);
    return r;
  endfunction

  task automatic drive_unit(input int u, input fu_result_t r);
    case (u)
      0:       arith_res.fu = r;
      1:       mul_res = r;
      2:       div_res = r;
      default: ls_res = r;
    endcase
    cycle();
  endtask

  task automatic push_retire(input int s, input logic wen, input logic [31:0] wdata,
                             input logic exc, input logic [31:0] cause, input logic redir,
                             input logic [31:0] target);
    retire_info_t e;
    e.valid     = 1'b1;
    e.rd        = rd_of[s];
    e.wen       = wen;
    e.wdata     = wdata;
    e.exception = exc;
    e.cause     = cause_t'(cause[2:0]);
    e.epc       = pc_of[s];
    e.redirect  = redir;
    e.target    = target;
    chk_i.expect_retire(e);
  endtask

  initial begin
    int fd;
    int s;
    string line;
    string cmd;
    string name;
    logic [31:0] a0, a1, a2, a3, a4, a5, a6;
    pred_update_t p;
    nRST      = 1'b0;
    stall     = 1'b0;
    halt      = 1'b0;
    alloc     = '0;
    arith_res = '0;
    mul_res   = '0;
    div_res   = '0;
    ls_res    = '0;
    repeat (3) @(posedge CLK);
    #2;
    nRST = 1'b1;
    fd = $fopen("tests/commit_input.txt", "r");
    if (fd == 0) give_up("cannot open tests/commit_input.txt");
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line.getc(0) == 8'h23) continue;  // Blank or comment
      cmd = "";
      a0 = '0;
      a1 = '0;
      a2 = '0;
      a3 = '0;
      a4 = '0;
      a5 = '0;
      a6 = '0;
      void'($sscanf(line, "%s %h %h %h %h %h %h %h", cmd, a0, a1, a2, a3, a4, a5, a6));
      s = int'(a0);
      if (cmd == "test") begin
        void'($sscanf(line, "%s %s", cmd, name));
        chk_i.start_test(name);
      end else if (cmd == "end") begin
        drain();
        chk_i.finish_test();
      end else if (cmd == "wait") drain();
      else if (cmd == "alloc") do_alloc(s, a1, a2, a3);
      else if (cmd == "res") drive_unit(int'(a0), make_result(int'(a1), a2, a3[0], a4));
      else if (cmd == "rdrive") begin
        rnd_of[a1] = $random(seed);
        drive_unit(int'(a0), make_result(int'(a1), rnd_of[a1], 1'b0, 0));
      end else if (cmd == "rexp") begin
        push_retire(s, rd_of[s] != '0, rnd_of[s], 1'b0, 0, 1'b0, 0);  // x0 never written
      end else if (cmd == "exp") push_retire(s, a1[0], a2, a3[0], a4, a5[0], a6);
      else if (cmd == "br") begin
        arith_res.branch_instr  = 1'b1;
        arith_res.prediction    = a1[0];
        arith_res.branch_taken  = a2[0];
        arith_res.resolved_addr = a3;
        drive_unit(0, make_result(s, 0, 1'b0, 0));
      end else if (cmd == "jmp") begin
        arith_res.jump_instr = 1'b1;
        arith_res.jump_addr  = a1;
        drive_unit(0, make_result(s, 0, 1'b0, 0));
      end else if (cmd == "pexp") begin
        p = '{valid: 1'b1, pc: pc_of[s], prediction: a1[0], taken: a2[0], target: a3};
        chk_i.expect_pred(p);
      end else if (cmd == "stall") begin
        stall = a0[0];
        cycle();
      end else if (cmd == "halt") begin
        halt = 1'b1;
        cycle();
        halt = 1'b0;
      end else if (cmd == "idle") repeat (int'(a0)) cycle();
      else if (cmd == "full") chk_i.check_field("cb_full", 32'(a0[0]), 32'(cb_full));
      else if (cmd == "idx") chk_i.check_field("alloc_index", a1, 32'(idx_of[s]));
      else chk_i.note_error($sformatf("unknown command %s in stimulus file", cmd));
    end
    $fclose(fd);
    chk_i.report_counts();
    if (chk_i.error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: ooo_commit.f
+incdir+rtl
rtl/ooo_commit_pkg.sv
rtl/ex_commit_latch.sv
rtl/commit_writeback.sv
rtl/completion_buffer.sv
rtl/retire_unit.sv
rtl/ooo_commit_top.sv
tests/commit_checker.sv
tests/tb_ooo_commit.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/100ps -j 0
TOP      = tb_ooo_commit
FILELIST = ooo_commit.f

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Exit status follows the pass message search
run: build
	./obj_dir/V$(TOP) | awk '{ print } /\*\* PASS \*\*/ { ok = 1 } END { exit !ok }'

lint:
	$(TOOL) --lint-only --timing --timescale 1ns/100ps --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// File: tests/commit_input.txt
# Columns: command then hex fields; seq numbers are hex, kind 0 ALU 1 BRANCH 2 JUMP 3 LOAD
# alloc seq pc rd kind | res unit seq wdata exc cause | exp seq wen wdata exc cause redir target
test order
alloc 0 100 1 0
alloc 1 104 2 3
alloc 2 108 3 0
alloc 3 10c 4 0
exp 0 1 11111111 0 0 0 0
exp 1 1 22222222 0 0 0 0
exp 2 1 33333333 0 0 0 0
exp 3 1 44444444 0 0 0 0
res 3 3 44444444 0 0
res 2 2 33333333 0 0
res 1 1 22222222 0 0
res 0 0 11111111 0 0
end
test alu_random
alloc 4 110 5 0
alloc 5 114 0 0
rdrive 0 4
rdrive 1 5
rexp 4
rexp 5
end
test branch
alloc 6 200 0 1
alloc 7 204 0 1
alloc 8 208 6 0
alloc 9 20c 7 0
pexp 6 1 1 300
exp 6 0 0 0 0 0 0
pexp 7 0 1 400
exp 7 0 0 0 0 1 400
br 6 1 1 300
br 7 0 1 400
res 1 8 55 0 0
res 2 9 66 0 0
idle 6
end
test jump
alloc 10 400 8 2
exp 10 1 404 0 0 1 500
jmp 10 500
end
test jump_misaligned
alloc 11 500 9 2
alloc 12 504 a 0
exp 11 0 500 1 1 0 0
jmp 11 502
res 1 12 77 0 0
idle 6
end
test load_exception
alloc 13 600 b 3
alloc 14 604 c 0
exp 13 0 600 1 2 0 0
res 3 13 0 1 2
idle 4
end
test refill
alloc 15 700 d 0
idx 15 0
exp 15 1 abcd 0 0 0 0
res 1 15 abcd 0 0
end
test full
alloc 16 800 1 0
alloc 17 804 1 0
alloc 18 808 1 0
alloc 19 80c 1 0
alloc 20 810 1 0
alloc 21 814 1 0
alloc 22 818 1 0
alloc 23 81c 1 0
full 1
exp 16 1 5 0 0 0 0
res 0 16 5 0 0
wait
full 0
halt
end
test stall_halt
alloc 24 900 e 0
stall 1
res 1 24 beef 0 0
idle 3
stall 0
exp 24 1 beef 0 0 0 0
wait
alloc 25 a00 f 0
res 2 25 1234 0 0
halt
idle 5
full 0
end
